// ==== src.f ====
rtl/rmii_line_pkg.sv
rtl/mii_mac_pkg.sv
rtl/mii_rx_if.sv
rtl/rmii_tx.sv
rtl/rmii_rx.sv
rtl/mii_to_rmii.sv
verification/tb_clock_gen.sv
verification/tb_mii_to_rmii.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_mii_to_rmii -f src.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_mii_to_rmii)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== verification/tb_mii_to_rmii.sv ====
/*
 * Directed testbench for the MII to RMII bridge at 100 Mb/s.
 * Inputs change on rising edges, outputs are sampled on falling edges.
 * Each received frame starts with seven 01 dibits and an 11 dibit.
 * A watchdog bounds the run by the total nibble count.
 */
module tb_mii_to_rmii;
   timeunit 1ns;
   timeprecision 100ps;

   import rmii_line_pkg::*;
   import mii_mac_pkg::*;

   localparam integer DIBIT_REPEAT    = REPEAT_100M;
   localparam integer TX_NIBBLES      = 16;
   localparam integer RX_NIBBLES      = 10;
   localparam integer TOTAL_NIBBLES   = TX_NIBBLES + 3 * RX_NIBBLES;
   localparam integer WATCHDOG_CYCLES = TOTAL_NIBBLES * 2 * DIBIT_REPEAT + 200;
   localparam logic [31:0] SEED       = 32'hdf58;

   logic    clk;
   logic    rst_n_i;
   nibble_t mac_txd_i;
   logic    mac_tx_en_i;
   logic    mac_tx_stb_o;
   nibble_t mac_rxd_o;
   logic    mac_rx_dv_o;
   logic    mac_rx_er_o;
   logic    mac_crs_o;
   logic    mac_rx_stb_o;
   dibit_t  phy_rxd_i;
   logic    phy_crs_dv_i;
   logic    phy_rx_er_i;
   dibit_t  phy_txd_o;
   logic    phy_tx_en_o;

   int      err_cnt;

   // Line stream of one receive frame starting at the first 01 dibit
   dibit_t  frm_d[$];
   logic    frm_crs[$];
   logic    frm_er[$];

   // MAC side view at every receive strobe
   nibble_t rx_nib[$];
   logic    rx_dv[$];
   logic    rx_er[$];
   logic    rx_crs[$];

   tb_clock_gen u_clock_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n_i)
   );

   mii_to_rmii #(
      .DIBIT_REPEAT (DIBIT_REPEAT)
   ) u_mii_to_rmii (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .mac_txd_i    (mac_txd_i),
      .mac_tx_en_i  (mac_tx_en_i),
      .mac_tx_stb_o (mac_tx_stb_o),
      .mac_rxd_o    (mac_rxd_o),
      .mac_rx_dv_o  (mac_rx_dv_o),
      .mac_rx_er_o  (mac_rx_er_o),
      .mac_crs_o    (mac_crs_o),
      .mac_rx_stb_o (mac_rx_stb_o),
      .phy_rxd_i    (phy_rxd_i),
      .phy_crs_dv_i (phy_crs_dv_i),
      .phy_rx_er_i  (phy_rx_er_i),
      .phy_txd_o    (phy_txd_o),
      .phy_tx_en_o  (phy_tx_en_o)
   );

   always @(negedge clk) begin
      if (mac_rx_stb_o) begin
         rx_nib.push_back(mac_rxd_o);
         rx_dv.push_back(mac_rx_dv_o);
         rx_er.push_back(mac_rx_er_o);
         rx_crs.push_back(mac_crs_o);
      end
   end

   task automatic compare(input string label, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual) begin
         err_cnt++;
         $display("[FAIL] %s: expected %0h, actual %0h", label, expected, actual);
      end
   endtask

   task automatic check_outputs_low(input string label);
      compare({label, " phy_tx_en_o"}, 32'(0), 32'(phy_tx_en_o));
      compare({label, " phy_txd_o"}, 32'(0), 32'(phy_txd_o));
      compare({label, " mac_tx_stb_o"}, 32'(0), 32'(mac_tx_stb_o));
      compare({label, " mac_rx_stb_o"}, 32'(0), 32'(mac_rx_stb_o));
      compare({label, " mac_rx_dv_o"}, 32'(0), 32'(mac_rx_dv_o));
      compare({label, " mac_rx_er_o"}, 32'(0), 32'(mac_rx_er_o));
      compare({label, " mac_crs_o"}, 32'(0), 32'(mac_crs_o));
   endtask

   // Returns in the rising edge at which the DUT samples the MAC nibble
   task automatic wait_tx_strobe();
      do @(negedge clk); while (!mac_tx_stb_o);
      @(posedge clk);
   endtask

   task automatic send_dibit(input dibit_t d, input logic crs_dv, input logic er);
      repeat (DIBIT_REPEAT) begin
         @(posedge clk);
         phy_rxd_i    <= d;
         phy_crs_dv_i <= crs_dv;
         phy_rx_er_i  <= er;
      end
   endtask

   task automatic push_dibit(input dibit_t d, input logic crs_dv, input logic er);
      frm_d.push_back(d);
      frm_crs.push_back(crs_dv);
      frm_er.push_back(er);
   endtask

   // Preamble and SFD give nibbles 5, 5, 5, D
   task automatic load_preamble();
      frm_d.delete();
      frm_crs.delete();
      frm_er.delete();
      repeat (7) push_dibit(DIBIT_PREAMBLE, 1'b1, 1'b0);
      push_dibit(2'b11, 1'b1, 1'b0);
   endtask

   task automatic push_random_data(input int count);
      repeat (count) push_dibit(2'($urandom), 1'b1, 1'b0);
   endtask

   task automatic play_frame(input string label, input int lead_zeros);
      int cnt;
      rx_nib.delete();
      rx_dv.delete();
      rx_er.delete();
      rx_crs.delete();
      repeat (lead_zeros) send_dibit(2'b00, 1'b1, 1'b0);
      foreach (frm_d[i]) send_dibit(frm_d[i], frm_crs[i], frm_er[i]);
      // Closing pair with crs_dv low on both halves
      send_dibit(2'b00, 1'b0, 1'b0);
      send_dibit(2'b00, 1'b0, 1'b0);
      cnt = 0;
      @(negedge clk);
      while ((mac_rx_dv_o || mac_crs_o) && cnt < 8 * DIBIT_REPEAT) begin
         @(negedge clk);
         cnt++;
      end
      if (mac_rx_dv_o || mac_crs_o) begin
         err_cnt++;
         $display("%s: receive frame did not end after crs_dv dropped", label);
      end
      // Idle gap so that any late strobe lands in the queues
      repeat (8 * DIBIT_REPEAT) @(negedge clk);
   endtask

   // First dibit of a pair is the low half and crs drops once a pair opens low
   task automatic check_rx_stream(input string label);
      int      n_exp;
      int      n_chk;
      nibble_t exp_nib;
      logic    exp_er;
      logic    crs_live;
      n_exp = frm_d.size() / 2;
      compare({label, " nibble count"}, 32'(n_exp), 32'(rx_nib.size()));
      n_chk = (rx_nib.size() < n_exp) ? rx_nib.size() : n_exp;
      crs_live = 1'b1;
      for (int k = 0; k < n_chk; k++) begin
         exp_nib = {frm_d[2 * k + 1], frm_d[2 * k]};
         exp_er  = frm_er[2 * k] | frm_er[2 * k + 1];
         if (!frm_crs[2 * k]) begin
            crs_live = 1'b0;
         end
         compare($sformatf("%s nibble %0d", label, k), 32'(exp_nib), 32'(rx_nib[k]));
         compare($sformatf("%s rx_dv %0d", label, k), 32'(1), 32'(rx_dv[k]));
         compare($sformatf("%s rx_er %0d", label, k), 32'(exp_er), 32'(rx_er[k]));
         compare($sformatf("%s crs %0d", label, k), 32'(crs_live), 32'(rx_crs[k]));
      end
   endtask

   task automatic reset_outputs_low();
      @(negedge clk);
      check_outputs_low("reset asserted");
      @(posedge rst_n_i);
      @(negedge clk);
      check_outputs_low("reset released");
   endtask

   task automatic transmit_random_frame();
      nibble_t nib[TX_NIBBLES];
      dibit_t  exp_q[$];
      dibit_t  got_q[$];
      int      n_chk;
      for (int n = 0; n < TX_NIBBLES; n++) begin
         nib[n] = 4'($urandom);
         repeat (DIBIT_REPEAT) exp_q.push_back(nib[n][1:0]);
         repeat (DIBIT_REPEAT) exp_q.push_back(nib[n][3:2]);
      end
      fork
         begin
            wait_tx_strobe();
            mac_txd_i   <= nib[0];
            mac_tx_en_i <= 1'b1;
            for (int n = 0; n < TX_NIBBLES; n++) begin
               wait_tx_strobe();
               if (n < TX_NIBBLES - 1) begin
                  mac_txd_i <= nib[n + 1];
               end else begin
                  mac_txd_i   <= '0;
                  mac_tx_en_i <= 1'b0;
               end
            end
         end
         begin
            do @(negedge clk); while (!phy_tx_en_o);
            while (phy_tx_en_o) begin
               got_q.push_back(phy_txd_o);
               @(negedge clk);
            end
         end
      join
      compare("tx frame dibit count", 32'(exp_q.size()), 32'(got_q.size()));
      n_chk = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
      for (int i = 0; i < n_chk; i++) begin
         compare($sformatf("tx frame dibit %0d", i), 32'(exp_q[i]), 32'(got_q[i]));
      end
      repeat (4 * DIBIT_REPEAT) @(negedge clk);
      compare("tx frame tx_en after frame", 32'(0), 32'(phy_tx_en_o));
   endtask

   task automatic false_carrier_frame();
      load_preamble();
      push_random_data(12);
      play_frame("false carrier", 3);
      check_rx_stream("false carrier");
      if (rx_nib.size() > 0) begin
         compare("false carrier first nibble", 32'(NIBBLE_PREAMBLE), 32'(rx_nib[0]));
      end
   endtask

   task automatic crs_dv_toggle_end();
      load_preamble();
      push_random_data(8);
      // Two pairs with crs_dv low then high as a PHY drains its FIFO
      repeat (2) begin
         push_dibit(2'($urandom), 1'b0, 1'b0);
         push_dibit(2'($urandom), 1'b1, 1'b0);
      end
      play_frame("crs_dv toggle", 1);
      check_rx_stream("crs_dv toggle");
      if (rx_crs.size() > 0) begin
         compare("crs_dv toggle crs at last nibble", 32'(0), 32'(rx_crs[rx_crs.size() - 1]));
      end
      compare("crs_dv toggle rx_dv after frame", 32'(0), 32'(mac_rx_dv_o));
   endtask

   task automatic rx_error_flag();
      int idx;
      load_preamble();
      push_random_data(12);
      idx = 8 + int'($urandom % 12);
      frm_er[idx] = 1'b1;
      play_frame("rx error", 1);
      check_rx_stream("rx error");
   endtask

   initial begin
      mac_txd_i    = '0;
      mac_tx_en_i  = 1'b0;
      phy_rxd_i    = '0;
      phy_crs_dv_i = 1'b0;
      phy_rx_er_i  = 1'b0;
      err_cnt      = 0;
      void'($urandom(SEED));
      reset_outputs_low();
      transmit_random_frame();
      false_carrier_frame();
      crs_dv_toggle_end();
      rx_error_flag();
      $display("Error count: %0d", err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Run timed out after %0d cycles, error count %0d", WATCHDOG_CYCLES, err_cnt);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source.
 * clk_o runs at 20 ns. rst_n_o is low from time zero and is released
 * on the fifth rising edge, so the DUT sees five edges in reset.
 */
module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam integer RESET_CYCLES = 5;

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// ==== rtl/mii_to_rmii.sv ====
/*
 * MII to RMII bridge on one 50 MHz reference clock.
 * DIBIT_REPEAT selects line speed, REPEAT_100M or REPEAT_10M.
 * MII clocks are replaced by mac_tx_stb_o and mac_rx_stb_o pulses.
 * Not covered: MDIO, PHY reset, the 45 degree PHY clock, collision and
 * tx_er. The PHY reference clock must come from the board top.
 */
module mii_to_rmii #(
   parameter integer DIBIT_REPEAT = rmii_line_pkg::REPEAT_100M
) (
   input  logic                  clk,
   input  logic                  rst_n_i,

   // MAC transmit
   input  mii_mac_pkg::nibble_t  mac_txd_i,
   input  logic                  mac_tx_en_i,
   output logic                  mac_tx_stb_o,

   // MAC receive
   output mii_mac_pkg::nibble_t  mac_rxd_o,
   output logic                  mac_rx_dv_o,
   output logic                  mac_rx_er_o,
   output logic                  mac_crs_o,
   output logic                  mac_rx_stb_o,

   // RMII PHY
   input  rmii_line_pkg::dibit_t phy_rxd_i,
   input  logic                  phy_crs_dv_i,
   input  logic                  phy_rx_er_i,
   output rmii_line_pkg::dibit_t phy_txd_o,
   output logic                  phy_tx_en_o
);

   mii_rx_if mii_rx ();

   rmii_tx #(
      .DIBIT_REPEAT (DIBIT_REPEAT)
   ) u_tx (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .txd_i       (mac_txd_i),
      .tx_en_i     (mac_tx_en_i),
      .tx_stb_o    (mac_tx_stb_o),
      .phy_txd_o   (phy_txd_o),
      .phy_tx_en_o (phy_tx_en_o)
   );

   rmii_rx #(
      .DIBIT_REPEAT (DIBIT_REPEAT)
   ) u_rx (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .phy_rxd_i    (phy_rxd_i),
      .phy_crs_dv_i (phy_crs_dv_i),
      .phy_rx_er_i  (phy_rx_er_i),
      .mii          (mii_rx)
   );

   // Receive bundle out to plain MAC ports
   assign mac_rxd_o    = mii_rx.rxd;
   assign mac_rx_dv_o  = mii_rx.rx_dv;
   assign mac_rx_er_o  = mii_rx.rx_er;
   assign mac_crs_o    = mii_rx.crs;
   assign mac_rx_stb_o = mii_rx.stb;

endmodule

// ==== rtl/rmii_rx.sv ====
/*
 * RMII receive path, dibit stream to nibble stream.
 * One sample per DIBIT_REPEAT cycles, phase restarted when crs_dv rises
 * from idle. Leading 00 dibits are skipped and alignment starts on the
 * first 01 dibit, so every nibble is built from an aligned pair.
 * crs_dv is split per pair: first half low drops carrier sense, both
 * halves low ends the frame. Other non-01 dibits before alignment are
 * also skipped.
 */
module rmii_rx #(
   parameter integer DIBIT_REPEAT = 1
) (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  rmii_line_pkg::dibit_t phy_rxd_i,
   input  logic                  phy_crs_dv_i,
   input  logic                  phy_rx_er_i,
   mii_rx_if.decoder             mii
);
   import rmii_line_pkg::*;
   import mii_mac_pkg::*;

   localparam integer CNT_W = (DIBIT_REPEAT > 1) ? $clog2(DIBIT_REPEAT) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIBIT_REPEAT - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_PRE,
      ST_IN_FRAME
   } state_t;

   state_t           state_q;
   logic [CNT_W-1:0] smp_cnt_q;
   logic             start;
   logic             smp_en;
   // Low half of the current pair is held
   logic             half_q;
   dibit_t           low_q;
   logic             low_er_q;
   logic             low_crs_q;
   nibble_t          rxd_q;
   logic             stb_q;
   logic             dv_q;
   logic             er_q;
   logic             crs_q;

   // Carrier seen while idle restarts the sample phase
   assign start  = (state_q == ST_IDLE) && phy_crs_dv_i;
   assign smp_en = start || ((state_q != ST_IDLE) && (smp_cnt_q == CNT_LAST));

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         smp_cnt_q <= '0;
      end else if (smp_en) begin
         smp_cnt_q <= '0;
      end else if (smp_cnt_q != CNT_LAST) begin
         smp_cnt_q <= smp_cnt_q + 1'b1;
      end
   end

   // Low half and its flags, taken on every sample outside a pair
   always_ff @(posedge clk) begin
      if (smp_en && !half_q) begin
         low_q     <= phy_rxd_i;
         low_er_q  <= phy_rx_er_i;
         low_crs_q <= phy_crs_dv_i;
      end
      if (smp_en && half_q) begin
         rxd_q <= {phy_rxd_i, low_q};
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         half_q  <= 1'b0;
         stb_q   <= 1'b0;
         dv_q    <= 1'b0;
         er_q    <= 1'b0;
         crs_q   <= 1'b0;
      end else begin
         stb_q <= 1'b0;
         er_q  <= 1'b0;
         if (smp_en) begin
            case (state_q)
               ST_IDLE: begin
                  crs_q <= 1'b1;
                  if (phy_rxd_i == DIBIT_PREAMBLE) begin
                     state_q <= ST_IN_FRAME;
                     half_q  <= 1'b1;
                  end else begin
                     state_q <= ST_WAIT_PRE;
                  end
               end
               ST_WAIT_PRE: begin
                  if (!phy_crs_dv_i) begin
                     // False carrier, no preamble ever came
                     state_q <= ST_IDLE;
                     crs_q   <= 1'b0;
                  end else if (phy_rxd_i == DIBIT_PREAMBLE) begin
                     state_q <= ST_IN_FRAME;
                     half_q  <= 1'b1;
                  end
               end
               default: begin
                  if (!half_q) begin
                     half_q <= 1'b1;
                  end else begin
                     half_q <= 1'b0;
                     // Carrier is gone once a pair opens with crs_dv low
                     if (!low_crs_q) begin
                        crs_q <= 1'b0;
                     end
                     if (!low_crs_q && !phy_crs_dv_i) begin
                        state_q <= ST_IDLE;
                        dv_q    <= 1'b0;
                     end else begin
                        stb_q <= 1'b1;
                        dv_q  <= 1'b1;
                        er_q  <= low_er_q | phy_rx_er_i;
                     end
                  end
               end
            endcase
         end
      end
   end

   assign mii.rxd   = rxd_q;
   assign mii.stb   = stb_q;
   assign mii.rx_dv = dv_q;
   assign mii.rx_er = er_q;
   assign mii.crs   = crs_q;

endmodule

// ==== rtl/rmii_tx.sv ====
/*
 * RMII transmit path, nibble stream to dibit stream.
 * tx_stb_o pulses every 2*DIBIT_REPEAT cycles and runs freely from reset.
 * The MAC must present txd_i and tx_en_i in the strobe cycle.
 * No back-pressure and no tx_er, RMII has no pin for it.
 * phy_txd_o is forced to 00 while phy_tx_en_o is low.
 */
module rmii_tx #(
   parameter integer DIBIT_REPEAT = 1
) (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  mii_mac_pkg::nibble_t  txd_i,
   input  logic                  tx_en_i,
   output logic                  tx_stb_o,
   output rmii_line_pkg::dibit_t phy_txd_o,
   output logic                  phy_tx_en_o
);
   import mii_mac_pkg::*;

   localparam integer CNT_W = (DIBIT_REPEAT > 1) ? $clog2(DIBIT_REPEAT) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIBIT_REPEAT - 1);

   // Cycles spent on the current dibit
   logic [CNT_W-1:0] hold_cnt_q;
   // 0 while the low dibit is out, 1 for the high dibit
   logic             half_q;
   nibble_t          nibble_q;
   logic             tx_en_q;

   // Strobe on the last cycle of the high dibit
   assign tx_stb_o = half_q && (hold_cnt_q == CNT_LAST);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_cnt_q <= '0;
         half_q     <= 1'b0;
      end else if (hold_cnt_q == CNT_LAST) begin
         hold_cnt_q <= '0;
         half_q     <= ~half_q;
      end else begin
         hold_cnt_q <= hold_cnt_q + 1'b1;
      end
   end

   // Enable follows the nibble it was sampled with
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tx_en_q <= 1'b0;
      end else if (tx_stb_o) begin
         tx_en_q <= tx_en_i;
      end
   end

   always_ff @(posedge clk) begin
      if (tx_stb_o) begin
         nibble_q <= txd_i;
      end
   end

   // Low dibit first
   always_comb begin
      if (!tx_en_q) begin
         phy_txd_o = '0;
      end else if (half_q) begin
         phy_txd_o = nibble_q[3:2];
      end else begin
         phy_txd_o = nibble_q[1:0];
      end
   end

   assign phy_tx_en_o = tx_en_q;

endmodule

// ==== rtl/mii_rx_if.sv ====
/*
 * MII receive signals between the RMII decoder and the MAC side.
 * All signals are synchronous to the reference clock. rxd and rx_er are
 * only meaningful in a cycle with stb high. crs and rx_dv are levels.
 */
interface mii_rx_if;
   import mii_mac_pkg::*;

   nibble_t rxd;
   logic    rx_dv;
   logic    rx_er;
   logic    crs;
   // One pulse per received nibble
   logic    stb;

   // Bridge side, produces the receive stream
   modport decoder (
      output rxd,
      output rx_dv,
      output rx_er,
      output crs,
      output stb
   );

   // MAC side, consumes it
   modport mac (
      input rxd,
      input rx_dv,
      input rx_er,
      input crs,
      input stb
   );

endinterface

// ==== rtl/mii_mac_pkg.sv ====
/*
 * MAC side of the RMII bridge.
 * The MAC sees a 4-bit MII nibble stream with the low nibble of each byte
 * first. MII clocks are replaced by single-cycle strobes on the reference
 * clock, so nothing here depends on line speed.
 */
package mii_mac_pkg;

   // One MII data nibble
   typedef logic [3:0] nibble_t;

   // Preamble nibble as seen on rxd once the receive path is aligned
   // Two 01 dibits, low half first
   localparam nibble_t NIBBLE_PREAMBLE = 4'h5;

endpackage

// ==== rtl/rmii_line_pkg.sv ====
/*
 * PHY side of the RMII bridge.
 * One dibit per RMII line symbol, sampled on the 50 MHz reference clock.
 * Hold counts give the number of reference clock cycles per dibit for each
 * line speed. Only 100 Mb/s and 10 Mb/s are defined.
 */
package rmii_line_pkg;

   // One RMII line symbol, bit 0 first on the wire
   typedef logic [1:0] dibit_t;

   // Reference clock cycles each dibit is held
   // 100 Mb/s moves one dibit per cycle
   localparam integer REPEAT_100M = 1;
   // 10 Mb/s repeats each dibit ten times
   localparam integer REPEAT_10M  = 10;

   // First dibit that carries meaning after crs_dv rises
   // Leading 00 dibits before it are idle line
   localparam dibit_t DIBIT_PREAMBLE = 2'b01;

endpackage
